// File: cmd_executor.f
+incdir+hw
hw/exec_pkg.sv
hw/cmd_sequencer.sv
hw/reply_formatter.sv
hw/io_register_file.sv
hw/irq_controller.sv
hw/cmd_executor.sv
tb/tb_cmd_executor_sva.sv
tb/tb_cmd_executor.sv

// File: Makefile
# Verilator build and run for the command executor testbench

VERILATOR ?= verilator
TOP       ?= tb_cmd_executor
FILELIST  ?= cmd_executor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

# Passes only if the simulator printed the pass line
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_cmd_executor.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module tb_cmd_executor;

    localparam int HOLDOFF       = 40;
    localparam int NUM_PKTS      = 400;
    localparam int TIMEOUT_LIMIT = NUM_PKTS * 60;
    localparam int ST_IDLE       = 0;
    localparam int ST_RWAIT      = 1;
    localparam int ST_RISSUE     = 2;
    localparam int ST_DELAY      = 3;
    localparam int ST_BUSY       = 4;

    logic                                          clk;
    logic                                          rst;
    exec_pkg::rx_pkt_t                             rx;
    logic                                          tx_busy;
    exec_pkg::tx_pkt_t                             tx;
    exec_pkg::reg_word_t [`EXEC_NUM_OUT_REGS-1:0]  out_regs;
    exec_pkg::reg_word_t [`EXEC_NUM_IN_REGS-1:0]   in_regs;
    exec_pkg::reg_word_t                           out_stbs;
    logic [`EXEC_NUM_IRQS-1:0]                     ints;

    // Reference model
    int                                            m_state;
    exec_pkg::reg_word_t [`EXEC_NUM_OUT_REGS-1:0]  m_out;
    logic [`EXEC_NUM_IRQS-1:0]                     m_mask;
    logic [`EXEC_NUM_IRQS-1:0]                     m_pend;
    int                                            m_timer;
    logic [`EXEC_REG_ADDR_W-1:0]                   m_sel;
    exec_pkg::reg_word_t                           m_indata;
    exec_pkg::tx_pkt_t                             exp_tx;
    exec_pkg::reg_word_t                           exp_stbs;

    // Values the DUT samples at the next edge
    exec_pkg::rx_pkt_t                             cur_rx;
    logic [`EXEC_NUM_IRQS-1:0]                     cur_ints;
    logic                                          cur_busy;
    exec_pkg::rx_pkt_t                             next_rx;
    int                                            busy_left;
    int                                            since_wr;
    int                                            irq_reports;
    int                                            cycles;
    integer                                        seed;

    cmd_executor #(
        .holdoff_cycles (HOLDOFF)
    ) u_cmd_executor (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .tx_busy  (tx_busy),
        .tx       (tx),
        .out_regs (out_regs),
        .in_regs  (in_regs),
        .out_stbs (out_stbs),
        .ints     (ints)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < TIMEOUT_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles", TIMEOUT_LIMIT);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [127:0] got,
                         input logic [127:0] expected);
        if (got !== expected)
        begin
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Little-endian word starting at byte k
    function automatic exec_pkg::reg_word_t word_at(input exec_pkg::rx_pkt_t p, input int k);
        return {p.data[k+3], p.data[k+2], p.data[k+1], p.data[k]};
    endfunction

    function automatic logic irq_ready_now();
        return ((m_pend & m_mask) != '0) && (m_timer == 0);
    endfunction

    task automatic put_reply(input exec_pkg::byte_t code, input exec_pkg::byte_t len,
                             input exec_pkg::reg_word_t word);
        exp_tx.wr        = 1'b1;
        exp_tx.len       = len;
        exp_tx.data[0]   = code;
        exp_tx.data[4:1] = word;
    endtask

    // One clock edge of the executor
    task automatic model_step(input exec_pkg::rx_pkt_t r, input logic [31:0] irq_in,
                              input logic busy);
        logic                        rdy;
        logic                        fire;
        logic                        clr_stb;
        logic [31:0]                 clr;
        logic [`EXEC_REG_ADDR_W-1:0] sel_old;
        rdy      = irq_ready_now();
        fire     = 1'b0;
        clr_stb  = 1'b0;
        clr      = '0;
        sel_old  = m_sel;
        exp_tx   = '0;
        exp_stbs = '0;
        case (m_state)
            ST_IDLE:
            begin
                if (r.done)
                begin
                    m_state = ST_DELAY;
                    if (r.len == 8'd0)
                        put_reply(`EXEC_RPL_OK, 8'd1, '0);
                    else
                    begin
                        case (r.data[0])
                            exec_pkg::OP_VERSION:
                                put_reply(`EXEC_RPL_OK, 8'd3,
                                          {16'h0, `EXEC_VER_LO, `EXEC_VER_HI});
                            exec_pkg::OP_WRITE_OUT:
                            begin
                                m_out[r.data[1][`EXEC_REG_ADDR_W-1:0]] = word_at(r, 2);
                                put_reply(`EXEC_RPL_OK, 8'd1, '0);
                            end
                            exec_pkg::OP_READ_IN:
                            begin
                                m_sel   = r.data[1][`EXEC_REG_ADDR_W-1:0];
                                m_state = ST_RWAIT;
                            end
                            exec_pkg::OP_OUT_STBS:
                            begin
                                exp_stbs = word_at(r, 1);
                                put_reply(`EXEC_RPL_OK, 8'd1, '0);
                            end
                            exec_pkg::OP_CLEAR_IRQ:
                            begin
                                clr_stb = 1'b1;
                                clr     = word_at(r, 1);
                                put_reply(`EXEC_RPL_OK, 8'd1, '0);
                            end
                            exec_pkg::OP_MASK_IRQ:
                            begin
                                m_mask = word_at(r, 1);
                                put_reply(`EXEC_RPL_OK, 8'd1, '0);
                            end
                            default:
                                put_reply(`EXEC_RPL_UNKNOWN, 8'd1, '0);
                        endcase
                    end
                end
                else if (r.error)
                begin
                    put_reply(`EXEC_RPL_ERROR, 8'd1, '0);
                    m_state = ST_DELAY;
                end
                else if (rdy)
                begin
                    put_reply(`EXEC_RPL_IRQ, 8'd5, m_pend);  // pending before this edge
                    fire    = 1'b1;
                    m_state = ST_DELAY;
                    irq_reports++;
                end
            end
            ST_RWAIT:
                m_state = ST_RISSUE;
            ST_RISSUE:
            begin
                put_reply(`EXEC_RPL_OK, 8'd5, m_indata);
                m_state = ST_DELAY;
            end
            ST_DELAY:
                m_state = ST_BUSY;
            default:
                if (!busy)
                    m_state = ST_IDLE;
        endcase
        m_indata = in_regs[sel_old];
        m_pend   = (m_pend & ~clr) | irq_in;
        if (clr_stb)
            m_timer = 0;
        else if (fire)
            m_timer = HOLDOFF;
        else if (m_timer != 0)
            m_timer = m_timer - 1;
    endtask

    task automatic compare_outputs();
        int i;
        check("tx.wr", 128'(tx.wr), 128'(exp_tx.wr));
        check("tx.len", 128'(tx.len), 128'(exp_tx.len));
        check("tx.data", 128'(tx.data), 128'(exp_tx.data));
        check("out_stbs", 128'(out_stbs), 128'(exp_stbs));
        for (i = 0; i < `EXEC_NUM_OUT_REGS; i++)
            check($sformatf("out_regs[%0d]", i), 128'(out_regs[i]), 128'(m_out[i]));
    endtask

    // Advance one clock, drive the next inputs, check at the falling edge
    task automatic cycle();
        logic [31:0] r;
        @(posedge clk);
        model_step(cur_rx, cur_ints, cur_busy);
        if (exp_tx.wr)
        begin
            r         = $random(seed);
            busy_left = 1 + int'(r[1:0]);  // transmitter busy 1 to 4 cycles
            since_wr  = 0;
        end
        else
        begin
            if (busy_left > 0)
                busy_left--;
            since_wr++;
        end
        r        = $random(seed);
        cur_ints = (r[5:0] == 6'd0) ? (32'd1 << r[12:8]) : '0;  // Sparse single lines
        cur_busy = (busy_left > 0);
        cur_rx   = next_rx;
        next_rx  = '0;
        rx      <= cur_rx;
        ints    <= cur_ints;
        tx_busy <= cur_busy;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic wait_idle();
        do
            cycle();
        while (!(m_state == ST_IDLE && !irq_ready_now() && !cur_busy && since_wr >= 3));
    endtask

    task automatic make_packet(output exec_pkg::rx_pkt_t p);
        logic [31:0] r;
        int          i;
        int          kind;
        p = '0;
        for (i = 0; i < `EXEC_PKT_BYTES; i++)
        begin
            r         = $random(seed);
            p.data[i] = r[7:0];
        end
        r     = $random(seed);
        kind  = int'(r % 32'd9);
        p.len = 8'd6 + {5'd0, r[18:16]};
        p.done = 1'b1;
        case (kind)
            0: p.len = 8'd0;
            1:
            begin
                p.done  = 1'b0;
                p.error = 1'b1;
            end
            2: p.data[0] = exec_pkg::OP_VERSION;
            3: p.data[0] = exec_pkg::OP_WRITE_OUT;
            4: p.data[0] = exec_pkg::OP_READ_IN;
            5: p.data[0] = exec_pkg::OP_OUT_STBS;
            6:
            begin
                p.data[0] = exec_pkg::OP_CLEAR_IRQ;
                if (r[8])
                    p.data[4:1] = '1;
            end
            7:
            begin
                p.data[0] = exec_pkg::OP_MASK_IRQ;
                if (r[9:8] == 2'd0)
                    p.data[4:1] = '0;          // everything masked off
                else if (r[9:8] == 2'd1)
                    p.data[4:1] = '1;
            end
            default:
                while (p.data[0] == exec_pkg::OP_VERSION ||
                       (p.data[0] >= exec_pkg::OP_WRITE_OUT &&
                        p.data[0] <= exec_pkg::OP_MASK_IRQ))
                begin
                    r         = $random(seed);
                    p.data[0] = r[7:0];
                end
        endcase
    endtask

    initial
    begin
        int          i;
        logic [31:0] r;
        seed    = 93;
        rst     = 1'b1;
        rx      = '0;
        tx_busy = 1'b0;
        ints    = '0;
        for (i = 0; i < `EXEC_NUM_IN_REGS; i++)
        begin
            r          = $random(seed);
            in_regs[i] = r;
        end
        cur_rx      = '0;
        cur_ints    = '0;
        cur_busy    = 1'b0;
        next_rx     = '0;
        busy_left   = 0;
        since_wr    = 3;
        irq_reports = 0;
        m_state     = ST_IDLE;
        m_out       = '0;
        m_mask      = '1;
        m_pend      = '0;
        m_timer     = 0;
        m_sel       = '0;
        m_indata    = '0;
        exp_tx      = '0;
        exp_stbs    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_outputs();  // Reset values
        for (i = 0; i < NUM_PKTS; i++)
        begin
            wait_idle();
            make_packet(next_rx);
            cycle();
        end
        repeat (2 * HOLDOFF) cycle();
        check("irq_reports nonzero", 128'(irq_reports != 0), 128'(1));
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: tb/tb_cmd_executor_sva.sv
`timescale 1ns/1ps

module tb_cmd_executor_sva (
    input logic                 clk,
    input logic                 rst,
    input exec_pkg::tx_pkt_t    tx,
    input logic                 tx_busy,
    input exec_pkg::reg_word_t  out_stbs
);

    // Every reply is a single write pulse
    assert property (@(posedge clk) disable iff (rst) tx.wr |=> !tx.wr)
        else $error("tx.wr was high for two cycles in a row");

    assert property (@(posedge clk) disable iff (rst) (out_stbs != '0) |=> (out_stbs == '0))
        else $error("out_stbs stayed nonzero for more than one cycle");

    // Transmitter busy at the edge that launched the write
    assert property (@(posedge clk) disable iff (rst) tx.wr |-> !$past(tx_busy))
        else $error("tx.wr issued while the transmitter was busy");

    assert property (@(posedge clk) disable iff (rst) tx.wr |-> (tx.len != 8'd0))
        else $error("tx.wr issued with a zero length");

endmodule

bind cmd_executor tb_cmd_executor_sva u_tb_cmd_executor_sva (
    .clk      (clk),
    .rst      (rst),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .out_stbs (out_stbs)
);

// File: hw/cmd_executor.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module cmd_executor #(
    parameter int holdoff_cycles = `EXEC_HOLDOFF_DEFAULT
) (
    input  logic                                          clk,
    input  logic                                          rst,
    input  exec_pkg::rx_pkt_t                             rx,
    input  logic                                          tx_busy,
    output exec_pkg::tx_pkt_t                             tx,
    output exec_pkg::reg_word_t [`EXEC_NUM_OUT_REGS-1:0]  out_regs,
    input  exec_pkg::reg_word_t [`EXEC_NUM_IN_REGS-1:0]   in_regs,
    output exec_pkg::reg_word_t                           out_stbs,
    input  logic [`EXEC_NUM_IRQS-1:0]                     ints
);

    exec_pkg::reply_e            reply;
    exec_pkg::out_wr_t           out_wr;
    logic                        in_sel_wr;
    logic [`EXEC_REG_ADDR_W-1:0] in_sel;
    exec_pkg::reg_word_t         in_data;
    logic                        clear_stb;
    logic [`EXEC_NUM_IRQS-1:0]   clear_vec;
    logic                        mask_stb;
    logic [`EXEC_NUM_IRQS-1:0]   mask_vec;
    logic                        irq_fire;
    logic                        irq_ready;
    logic [`EXEC_NUM_IRQS-1:0]   pending;

    cmd_sequencer u_cmd_sequencer (
        .clk       (clk),
        .rst       (rst),
        .rx        (rx),
        .tx_busy   (tx_busy),
        .irq_ready (irq_ready),
        .reply     (reply),
        .out_wr    (out_wr),
        .in_sel_wr (in_sel_wr),
        .in_sel    (in_sel),
        .out_stbs  (out_stbs),
        .clear_stb (clear_stb),
        .clear_vec (clear_vec),
        .mask_stb  (mask_stb),
        .mask_vec  (mask_vec),
        .irq_fire  (irq_fire)
    );

    reply_formatter u_reply_formatter (
        .clk     (clk),
        .rst     (rst),
        .reply   (reply),
        .in_data (in_data),
        .pending (pending),
        .tx      (tx)
    );

    io_register_file u_io_register_file (
        .clk       (clk),
        .rst       (rst),
        .out_wr    (out_wr),
        .in_sel_wr (in_sel_wr),
        .in_sel    (in_sel),
        .in_regs   (in_regs),
        .out_regs  (out_regs),
        .in_data   (in_data)
    );

    irq_controller #(
        .holdoff_cycles (holdoff_cycles)
    ) u_irq_controller (
        .clk       (clk),
        .rst       (rst),
        .ints      (ints),
        .clear_stb (clear_stb),
        .clear_vec (clear_vec),
        .mask_stb  (mask_stb),
        .mask_vec  (mask_vec),
        .irq_fire  (irq_fire),
        .pending   (pending),
        .irq_ready (irq_ready)
    );

endmodule

// File: hw/irq_controller.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module irq_controller #(
    parameter int holdoff_cycles = `EXEC_HOLDOFF_DEFAULT
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`EXEC_NUM_IRQS-1:0]  ints,
    input  logic                       clear_stb,
    input  logic [`EXEC_NUM_IRQS-1:0]  clear_vec,
    input  logic                       mask_stb,
    input  logic [`EXEC_NUM_IRQS-1:0]  mask_vec,
    input  logic                       irq_fire,
    output logic [`EXEC_NUM_IRQS-1:0]  pending,
    output logic                       irq_ready
);

    localparam int TIMER_W = $clog2(holdoff_cycles + 1);

    logic [`EXEC_NUM_IRQS-1:0] mask;
    logic [`EXEC_NUM_IRQS-1:0] clr;
    logic [TIMER_W-1:0]        timer;

    assign clr = clear_stb ? clear_vec : '0;

    // New lines win over a clear in the same cycle
    always_ff @(posedge clk)
    begin
        if (rst)
            pending <= '0;
        else
            pending <= (pending & ~clr) | ints;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            mask <= '1;              // everything enabled out of reset
        else if (mask_stb)
            mask <= mask_vec;
    end

    // Holdoff between reports
    always_ff @(posedge clk)
    begin
        if (rst)
            timer <= '0;
        else if (clear_stb)
            timer <= '0;
        else if (irq_fire)
            timer <= TIMER_W'(holdoff_cycles);
        else if (timer != '0)
            timer <= timer - 1'b1;
    end

    assign irq_ready = ((pending & mask) != '0) && (timer == '0);

endmodule

// File: hw/io_register_file.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module io_register_file (
    input  logic                                              clk,
    input  logic                                              rst,
    input  exec_pkg::out_wr_t                                 out_wr,
    input  logic                                              in_sel_wr,
    input  logic [`EXEC_REG_ADDR_W-1:0]                       in_sel,
    input  exec_pkg::reg_word_t [`EXEC_NUM_IN_REGS-1:0]       in_regs,
    output exec_pkg::reg_word_t [`EXEC_NUM_OUT_REGS-1:0]      out_regs,
    output exec_pkg::reg_word_t                               in_data
);

    logic [`EXEC_REG_ADDR_W-1:0] sel_q;

    // Output bank
    always_ff @(posedge clk)
    begin
        if (rst)
            out_regs <= '0;
        else if (out_wr.stb)
            out_regs[out_wr.addr] <= out_wr.data;
    end

    // Input select held between reads
    always_ff @(posedge clk)
    begin
        if (rst)
            sel_q <= '0;
        else if (in_sel_wr)
            sel_q <= in_sel;
    end

    // One edge after the select lands
    always_ff @(posedge clk)
    begin
        in_data <= in_regs[sel_q];
    end

endmodule

// File: hw/reply_formatter.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module reply_formatter (
    input  logic                       clk,
    input  logic                       rst,
    input  exec_pkg::reply_e           reply,
    input  exec_pkg::reg_word_t        in_data,
    input  logic [`EXEC_NUM_IRQS-1:0]  pending,
    output exec_pkg::tx_pkt_t          tx
);

    exec_pkg::tx_pkt_t tx_nxt;

    always_comb
    begin
        tx_nxt    = '0;
        tx_nxt.wr = (reply != exec_pkg::RPL_NONE);

        case (reply)
            exec_pkg::RPL_OK:
            begin
                tx_nxt.len     = 8'd1;
                tx_nxt.data[0] = `EXEC_RPL_OK;
            end
            exec_pkg::RPL_ERROR:
            begin
                tx_nxt.len     = 8'd1;
                tx_nxt.data[0] = `EXEC_RPL_ERROR;
            end
            exec_pkg::RPL_UNKNOWN:
            begin
                tx_nxt.len     = 8'd1;
                tx_nxt.data[0] = `EXEC_RPL_UNKNOWN;
            end
            exec_pkg::RPL_VERSION:
            begin
                tx_nxt.len     = 8'd3;
                tx_nxt.data[0] = `EXEC_RPL_OK;
                tx_nxt.data[1] = `EXEC_VER_HI;
                tx_nxt.data[2] = `EXEC_VER_LO;
            end
            exec_pkg::RPL_READ:
            begin
                tx_nxt.len       = 8'd5;
                tx_nxt.data[0]   = `EXEC_RPL_OK;
                tx_nxt.data[4:1] = in_data;    // lowest byte in data[1]
            end
            exec_pkg::RPL_IRQ:
            begin
                tx_nxt.len       = 8'd5;
                tx_nxt.data[0]   = `EXEC_RPL_IRQ;
                tx_nxt.data[4:1] = pending;
            end
            default:
                tx_nxt = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tx <= '0;
        else
            tx <= tx_nxt;
    end

endmodule

// File: hw/cmd_sequencer.sv
`timescale 1ns/1ps
`include "exec_params.svh"

module cmd_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  exec_pkg::rx_pkt_t             rx,
    input  logic                          tx_busy,
    input  logic                          irq_ready,
    output exec_pkg::reply_e              reply,
    output exec_pkg::out_wr_t             out_wr,
    output logic                          in_sel_wr,
    output logic [`EXEC_REG_ADDR_W-1:0]   in_sel,
    output exec_pkg::reg_word_t           out_stbs,
    output logic                          clear_stb,
    output logic [`EXEC_NUM_IRQS-1:0]     clear_vec,
    output logic                          mask_stb,
    output logic [`EXEC_NUM_IRQS-1:0]     mask_vec,
    output logic                          irq_fire
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ_WAIT,
        S_READ_ISSUE,
        S_DELAY,
        S_BUSY
    } state_e;

    state_e              state;
    state_e              state_nxt;
    exec_pkg::reg_word_t stbs_nxt;
    exec_pkg::reg_word_t arg_word;   // Bytes 1..4
    exec_pkg::reg_word_t wr_word;    // Bytes 2..5 after the register address

    // Little-endian fields with the lowest byte first
    assign arg_word = rx.data[4:1];
    assign wr_word  = rx.data[5:2];

    always_comb
    begin
        state_nxt    = state;
        reply        = exec_pkg::RPL_NONE;
        out_wr.stb   = 1'b0;
        out_wr.addr  = rx.data[1][`EXEC_REG_ADDR_W-1:0];
        out_wr.data  = wr_word;
        in_sel_wr    = 1'b0;
        in_sel       = rx.data[1][`EXEC_REG_ADDR_W-1:0];
        stbs_nxt     = '0;
        clear_stb    = 1'b0;
        clear_vec    = arg_word;
        mask_stb     = 1'b0;
        mask_vec     = arg_word;
        irq_fire     = 1'b0;

        case (state)
            S_IDLE:
            begin
                if (rx.done)
                begin
                    state_nxt = S_DELAY;
                    if (rx.len == '0)
                        reply = exec_pkg::RPL_OK;
                    else
                    begin
                        case (rx.data[0])
                            exec_pkg::OP_VERSION:
                                reply = exec_pkg::RPL_VERSION;
                            exec_pkg::OP_WRITE_OUT:
                            begin
                                out_wr.stb = 1'b1;
                                reply      = exec_pkg::RPL_OK;
                            end
                            exec_pkg::OP_READ_IN:
                            begin
                                in_sel_wr = 1'b1;
                                state_nxt = S_READ_WAIT; // reply once in_data settles
                            end
                            exec_pkg::OP_OUT_STBS:
                            begin
                                stbs_nxt = arg_word;
                                reply    = exec_pkg::RPL_OK;
                            end
                            exec_pkg::OP_CLEAR_IRQ:
                            begin
                                clear_stb = 1'b1;
                                reply     = exec_pkg::RPL_OK;
                            end
                            exec_pkg::OP_MASK_IRQ:
                            begin
                                mask_stb = 1'b1;
                                reply    = exec_pkg::RPL_OK;
                            end
                            default:
                                reply = exec_pkg::RPL_UNKNOWN;
                        endcase
                    end
                end
                else if (rx.error)
                begin
                    reply     = exec_pkg::RPL_ERROR;
                    state_nxt = S_DELAY;
                end
                else if (irq_ready)
                begin
                    reply     = exec_pkg::RPL_IRQ;
                    irq_fire  = 1'b1;
                    state_nxt = S_DELAY;
                end
            end
            S_READ_WAIT:
                state_nxt = S_READ_ISSUE;
            S_READ_ISSUE:
            begin
                reply     = exec_pkg::RPL_READ;
                state_nxt = S_DELAY;
            end
            S_DELAY:
                state_nxt = S_BUSY;  // give the transmitter a cycle to raise busy
            S_BUSY:
                if (!tx_busy)
                    state_nxt = S_IDLE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= S_IDLE;
            out_stbs <= '0;
        end
        else
        begin
            state    <= state_nxt;
            out_stbs <= stbs_nxt;
        end
    end

endmodule

// File: hw/exec_pkg.sv
`include "exec_params.svh"

package exec_pkg;

    typedef logic [`EXEC_BYTE_W-1:0] byte_t;
    typedef logic [`EXEC_REG_W-1:0]  reg_word_t;

    // Finished packet from the receiver
    typedef struct packed {
        logic                             done;
        logic                             error;
        byte_t                            len;
        byte_t [`EXEC_PKT_BYTES-1:0]      data;  // data[0] is the opcode
    } rx_pkt_t;

    // Packet handed to the transmitter
    typedef struct packed {
        logic                             wr;
        byte_t                            len;
        byte_t [`EXEC_PKT_BYTES-1:0]      data;
    } tx_pkt_t;

    typedef enum byte_t {
        OP_VERSION   = 8'd0,
        OP_WRITE_OUT = 8'd60,
        OP_READ_IN   = 8'd61,
        OP_OUT_STBS  = 8'd62,
        OP_CLEAR_IRQ = 8'd63,
        OP_MASK_IRQ  = 8'd64
    } opcode_e;

    typedef enum logic [2:0] {
        RPL_NONE,
        RPL_OK,
        RPL_ERROR,
        RPL_UNKNOWN,
        RPL_VERSION,
        RPL_READ,
        RPL_IRQ
    } reply_e;

    // One output register write
    typedef struct packed {
        logic                             stb;
        logic [`EXEC_REG_ADDR_W-1:0]      addr;
        reg_word_t                        data;
    } out_wr_t;

endpackage

// File: hw/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// Data widths
`define EXEC_BYTE_W            8
`define EXEC_REG_W             32

// Register banks
`define EXEC_NUM_OUT_REGS      64
`define EXEC_NUM_IN_REGS       64
`define EXEC_REG_ADDR_W        6

// Packet buffer depth in bytes
`define EXEC_PKT_BYTES         16

`define EXEC_NUM_IRQS          32

// First byte of each reply
`define EXEC_RPL_OK            8'h81
`define EXEC_RPL_ERROR         8'h80
`define EXEC_RPL_UNKNOWN       8'h85
`define EXEC_RPL_IRQ           8'h50

// Version query answer
`define EXEC_VER_HI            8'hBA
`define EXEC_VER_LO            8'hCE

// Cycles between interrupt reports
`define EXEC_HOLDOFF_DEFAULT   1000000

`endif
